// ==== hw/frameBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameBuffer (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input logic [frameReadoutPkg::ChanWidth-1:0] wrChan,
	input logic [frameReadoutPkg::AdrWidth-1:0] wrAdr,
	input logic [frameReadoutPkg::DataWidth-1:0] wrData,
	readIf.buff rdBus,
	output logic [frameReadoutPkg::DataWidth-1:0] byteOut,
	output logic byteValid
);

	logic [frameReadoutPkg::DataWidth-1:0] mem
		[frameReadoutPkg::NumChan][frameReadoutPkg::FrameWords];
	logic [frameReadoutPkg::DataWidth-1:0] dataReg;
	logic rdPrev;
	logic validReg;
	logic rdRise;

	assign rdRise = rdBus.rd & ~rdPrev;

	// write port.
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrChan][wrAdr] <= wrData;
		end
	end

	// read port with one word per read window.
	always_ff @(posedge clk) begin
		if (rdRise) begin
			dataReg <= mem[rdBus.chan][rdBus.adr];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdPrev <= 1'b0;
			validReg <= 1'b0;
		end else begin
			rdPrev <= rdBus.rd;
			validReg <= rdRise; // single clock pulse.
		end
	end

	assign byteOut = dataReg;
	assign byteValid = validReg;
	assign rdBus.data = dataReg;
	assign rdBus.valid = validReg;

endmodule

`default_nettype wire

// ==== hw/frameReadout.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameReadout (
	input logic clk,
	input logic rst,
	input logic [frameReadoutPkg::NumChan-1:0] strobe,
	input logic wrEn,
	input logic [frameReadoutPkg::ChanWidth-1:0] wrChan,
	input logic [frameReadoutPkg::AdrWidth-1:0] wrAdr,
	input logic [frameReadoutPkg::DataWidth-1:0] wrData,
	output logic txd,
	output logic busy
);

	logic [frameReadoutPkg::NumChan-1:0] pending;
	logic [frameReadoutPkg::NumChan-1:0] grant;
	logic [frameReadoutPkg::DataWidth-1:0] byteOut;
	logic byteValid;

	readIf rdBus ();

	strobeSync i_strobeSync (
		.clk(clk),
		.rst(rst),
		.strobe(strobe),
		.grant(grant),
		.pending(pending)
	);

	readSequencer i_readSequencer (
		.clk(clk),
		.rst(rst),
		.pending(pending),
		.grant(grant),
		.busy(busy),
		.rdBus(rdBus.seq)
	);

	frameBuffer i_frameBuffer (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrChan(wrChan),
		.wrAdr(wrAdr),
		.wrData(wrData),
		.rdBus(rdBus.buff),
		.byteOut(byteOut),
		.byteValid(byteValid)
	);

	// one byte per slot so the serializer never sees back-pressure.
	uartTx i_uartTx (
		.clk(clk),
		.rst(rst),
		.byteIn(byteOut),
		.byteValid(byteValid),
		.txd(txd)
	);

endmodule

`default_nettype wire

// ==== hw/frameReadoutPkg.sv ====
`default_nettype none

package frameReadoutPkg;

	localparam int NumChan = 5;
	localparam int FrameWords = 18;
	localparam int AdrWidth = 5;
	localparam int ChanWidth = 3;
	localparam int DataWidth = 8;

	localparam int SlotCycles = 224; // clocks per word slot.
	localparam int RdOnCycle = 40;
	localparam int RdOffCycle = 44;
	localparam int BitCycles = 16; // clocks per serial bit.

	// counter widths.
	localparam int SlotWidth = $clog2(SlotCycles);
	localparam int TimerWidth = $clog2(BitCycles);
	localparam int FrameBits = 10; // start, eight data, stop.
	localparam int BitIdxWidth = $clog2(FrameBits);

	// compare values sized to their counters.
	localparam logic [SlotWidth-1:0] SlotLast = SlotWidth'(SlotCycles - 1);
	localparam logic [SlotWidth-1:0] RdSetCnt = SlotWidth'(RdOnCycle - 1); // rd is registered.
	localparam logic [SlotWidth-1:0] RdClrCnt = SlotWidth'(RdOffCycle - 1);
	localparam logic [AdrWidth-1:0] WordLast = AdrWidth'(FrameWords - 1);
	localparam logic [TimerWidth-1:0] TimerLast = TimerWidth'(BitCycles - 1);
	localparam logic [BitIdxWidth-1:0] BitIdxLast = BitIdxWidth'(FrameBits - 1);

endpackage

`default_nettype wire

// ==== hw/readIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface readIf;

	logic rd; // read window of the current slot.
	logic [frameReadoutPkg::ChanWidth-1:0] chan;
	logic [frameReadoutPkg::AdrWidth-1:0] adr;
	logic [frameReadoutPkg::DataWidth-1:0] data;
	logic valid; // one clock per byte read.

	modport seq (
		output rd,
		output chan,
		output adr,
		input data,
		input valid
	);

	modport buff (
		input rd,
		input chan,
		input adr,
		output data,
		output valid
	);

endinterface

`default_nettype wire

// ==== hw/readSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module readSequencer (
	input logic clk,
	input logic rst,
	input logic [frameReadoutPkg::NumChan-1:0] pending,
	output logic [frameReadoutPkg::NumChan-1:0] grant,
	output logic busy,
	readIf.seq rdBus
);

	logic reading;
	logic rdReg;
	logic [frameReadoutPkg::SlotWidth-1:0] slotCnt;
	logic [frameReadoutPkg::AdrWidth-1:0] wordCnt;
	logic [frameReadoutPkg::ChanWidth-1:0] chanReg;
	logic [frameReadoutPkg::ChanWidth-1:0] lowIdx;
	logic [frameReadoutPkg::NumChan-1:0] lowest;

	// isolate the lowest pending bit.
	assign lowest = pending & (~pending + 1'b1);

	// the scan runs from the top so the lowest pending index lands last.
	always_comb begin
		lowIdx = '0;
		for (int i = frameReadoutPkg::NumChan - 1; i >= 0; i--) begin
			if (pending[i]) begin
				lowIdx = i[frameReadoutPkg::ChanWidth-1:0];
			end
		end
	end

	assign grant = reading ? '0 : lowest; // only while idle.
	assign busy = reading;

	assign rdBus.rd = rdReg;
	assign rdBus.chan = chanReg;
	assign rdBus.adr = wordCnt; // held for the whole slot.

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			reading <= 1'b0;
			rdReg <= 1'b0;
			slotCnt <= '0;
			wordCnt <= '0;
			chanReg <= '0;
		end else if (!reading) begin
			if (|pending) begin
				reading <= 1'b1;
				chanReg <= lowIdx;
			end
		end else begin
			// read window inside the slot.
			if (slotCnt == frameReadoutPkg::RdSetCnt) begin
				rdReg <= 1'b1;
			end else if (slotCnt == frameReadoutPkg::RdClrCnt) begin
				rdReg <= 1'b0;
			end

			if (slotCnt == frameReadoutPkg::SlotLast) begin
				slotCnt <= '0;
				if (wordCnt == frameReadoutPkg::WordLast) begin
					wordCnt <= '0;
					reading <= 1'b0; // frame done and free to grant again.
				end else begin
					wordCnt <= wordCnt + 1'b1;
				end
			end else begin
				slotCnt <= slotCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/strobeSync.sv ====
`timescale 1ns/1ns
`default_nettype none

module strobeSync (
	input logic clk,
	input logic rst,
	input logic [frameReadoutPkg::NumChan-1:0] strobe,
	input logic [frameReadoutPkg::NumChan-1:0] grant,
	output logic [frameReadoutPkg::NumChan-1:0] pending
);

	logic [frameReadoutPkg::NumChan-1:0] syncA;
	logic [frameReadoutPkg::NumChan-1:0] syncB;
	logic [frameReadoutPkg::NumChan-1:0] strobePrev;
	logic [frameReadoutPkg::NumChan-1:0] armed;
	logic [frameReadoutPkg::NumChan-1:0] rise;

	assign rise = syncB & ~strobePrev;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			syncA <= '0;
			syncB <= '0;
			strobePrev <= '0;
			armed <= '0;
			pending <= '0;
		end else begin
			syncA <= strobe;
			syncB <= syncA;
			strobePrev <= syncB; // edge register.

			// a channel re-arms only once its strobe is seen low.
			armed <= ~syncB | (armed & ~rise);

			// a fresh request wins over a grant in the same clock.
			pending <= (pending & ~grant) | (rise & armed);
		end
	end

endmodule

`default_nettype wire

// ==== hw/uartTx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uartTx (
	input logic clk,
	input logic rst,
	input logic [frameReadoutPkg::DataWidth-1:0] byteIn,
	input logic byteValid,
	output logic txd
);

	logic sending;
	logic [frameReadoutPkg::TimerWidth-1:0] bitTimer;
	logic [frameReadoutPkg::BitIdxWidth-1:0] bitIdx;
	logic [frameReadoutPkg::DataWidth:0] shiftReg; // stop bit above the data.
	logic bitEnd;

	assign bitEnd = sending && (bitTimer == frameReadoutPkg::TimerLast);

	always_ff @(posedge clk) begin
		if (!sending && byteValid) begin
			shiftReg <= {1'b1, byteIn};
		end else if (bitEnd) begin
			shiftReg <= shiftReg >> 1; // LSB first.
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sending <= 1'b0;
			txd <= 1'b1; // line idles high.
			bitTimer <= '0;
			bitIdx <= '0;
		end else if (!sending) begin
			if (byteValid) begin
				sending <= 1'b1;
				txd <= 1'b0; // start bit.
				bitTimer <= '0;
				bitIdx <= '0;
			end
		end else if (bitEnd) begin
			bitTimer <= '0;
			if (bitIdx == frameReadoutPkg::BitIdxLast) begin
				sending <= 1'b0;
				txd <= 1'b1;
			end else begin
				txd <= shiftReg[0];
				bitIdx <= bitIdx + 1'b1;
			end
		end else begin
			bitTimer <= bitTimer + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/frameReadoutPkg.sv
hw/readIf.sv
hw/strobeSync.sv
hw/readSequencer.sv
hw/frameBuffer.sv
hw/uartTx.sv
hw/frameReadout.sv
tests/frameReadoutProperties.sv
tests/frameReadoutTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module frameReadoutTb -f project.f -o simv

output=$(./obj_dir/simv)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q '^SIMULATION PASSED$'; then
	exit 0
else
	exit 1
fi

// ==== tests/frameReadoutProperties.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameReadoutProperties (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic [frameReadoutPkg::NumChan-1:0] grant,
	input logic [frameReadoutPkg::ChanWidth-1:0] chan,
	input logic busy,
	input logic byteValid,
	input logic sending
);

	// read window is four clocks.
	rdWindow: assert property (@(posedge clk) disable iff (!rst)
		$rose(rd) |=> rd ##1 rd ##1 rd ##1 !rd)
		else $error("rd window is not four clocks long");

	noBackPressure: assert property (@(posedge clk) disable iff (!rst)
		byteValid |-> !sending)
		else $error("byte valid while the serializer is still sending");

	// the granted bit must be the channel latched for the frame.
	grantOneHot: assert property (@(posedge clk) disable iff (!rst)
		grant != '0 |-> $onehot(grant) ##1 (($past(grant) >> chan) == 1))
		else $error("grant is not one-hot or does not match the channel read");

	busyAfterGrant: assert property (@(posedge clk) disable iff (!rst)
		$rose(busy) |-> $past(grant != '0))
		else $error("busy rose without a grant");

endmodule

// serializer inputs tied idle on the sequencer side.
bind readSequencer frameReadoutProperties seqProps (
	.clk(clk),
	.rst(rst),
	.rd(rdReg),
	.grant(grant),
	.chan(chanReg),
	.busy(busy),
	.byteValid(1'b0),
	.sending(1'b0)
);

bind uartTx frameReadoutProperties txProps (
	.clk(clk),
	.rst(rst),
	.rd(1'b0),
	.grant('0),
	.chan('0),
	.busy(1'b0),
	.byteValid(byteValid),
	.sending(sending)
);

`default_nettype wire

// ==== tests/frameReadoutTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameReadoutTb;

	localparam int NumRounds = 12;
	localparam int ClkPeriod = 20;
	localparam int FrameCycles = frameReadoutPkg::FrameWords * frameReadoutPkg::SlotCycles;
	localparam int BusyTolerance = 4;
	localparam int RiseLimit = 8; // clocks from strobe to busy.
	localparam longint WatchdogNs =
		longint'(NumRounds * frameReadoutPkg::NumChan * FrameCycles * ClkPeriod) + 200000;

	logic clk;
	logic rst;
	logic [frameReadoutPkg::NumChan-1:0] strobe;
	logic wrEn;
	logic [frameReadoutPkg::ChanWidth-1:0] wrChan;
	logic [frameReadoutPkg::AdrWidth-1:0] wrAdr;
	logic [frameReadoutPkg::DataWidth-1:0] wrData;
	logic txd;
	logic busy;

	integer seed;
	int errorCount = 0;
	int bytesChecked = 0;
	int framesSeen = 0;
	int framesExpected = 0;
	int busyLen = 0;

	// copy of the buffer contents.
	logic [frameReadoutPkg::DataWidth-1:0] model
		[frameReadoutPkg::NumChan][frameReadoutPkg::FrameWords];
	logic [frameReadoutPkg::DataWidth-1:0] expQ [$];

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	frameReadout i_dut (
		.clk(clk),
		.rst(rst),
		.strobe(strobe),
		.wrEn(wrEn),
		.wrChan(wrChan),
		.wrAdr(wrAdr),
		.wrData(wrData),
		.txd(txd),
		.busy(busy)
	);

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errorCount++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic writeWord(input int chan, input int adr,
			input logic [frameReadoutPkg::DataWidth-1:0] data);
		wrEn = 1'b1;
		wrChan = frameReadoutPkg::ChanWidth'(chan);
		wrAdr = frameReadoutPkg::AdrWidth'(adr);
		wrData = data;
		@(negedge clk);
		wrEn = 1'b0;
		model[chan][adr] = data;
	endtask

	task automatic rewriteRandom(input int count);
		int chanSel;
		int adrSel;
		for (int i = 0; i < count; i++) begin
			chanSel = $unsigned($random(seed)) % frameReadoutPkg::NumChan;
			adrSel = $unsigned($random(seed)) % frameReadoutPkg::FrameWords;
			writeWord(chanSel, adrSel, frameReadoutPkg::DataWidth'($random(seed)));
		end
	endtask

	// queue the frames of every armed channel that rises in ascending order.
	task automatic applyStrobes(input logic [frameReadoutPkg::NumChan-1:0] pattern);
		logic [frameReadoutPkg::NumChan-1:0] rising;
		int waited;
		rising = pattern & ~strobe;
		for (int c = 0; c < frameReadoutPkg::NumChan; c++) begin
			if (rising[c]) begin
				framesExpected++;
				for (int w = 0; w < frameReadoutPkg::FrameWords; w++) begin
					expQ.push_back(model[c][w]);
				end
			end
		end
		strobe = pattern;
		waited = 0;
		while (busy !== 1'b1 && waited < RiseLimit) begin
			@(negedge clk);
			waited++;
		end
		if (rising != '0 && busy !== 1'b1) begin
			errorCount++;
			$display("busy did not rise within %0d clocks of a strobe", RiseLimit);
		end else if (rising == '0) begin
			checkValue("busy", busy, 1'b0); // held strobes stay quiet.
		end
	endtask

	task automatic waitIdle;
		do begin
			@(negedge clk);
		end while (expQ.size() != 0 || busy !== 1'b0);
		repeat (4) @(negedge clk);
	endtask

	// called one half clock into the start bit.
	task automatic receiveByte(output logic [7:0] value, output logic stopBit);
		repeat (frameReadoutPkg::BitCycles / 2 - 1) @(negedge clk);
		if (txd !== 1'b0) begin
			errorCount++;
			$display("start bit on txd did not last to its middle");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (frameReadoutPkg::BitCycles) @(negedge clk);
			value[i] = txd; // LSB first.
		end
		repeat (frameReadoutPkg::BitCycles) @(negedge clk);
		stopBit = txd;
	endtask

	initial begin : txdDecoder
		logic prevTxd;
		logic [7:0] rxByte;
		logic [7:0] expByte;
		logic stopBit;
		prevTxd = 1'b1;
		wait (rst === 1'b1);
		forever begin
			@(negedge clk);
			if (prevTxd === 1'b1 && txd === 1'b0) begin
				receiveByte(rxByte, stopBit);
				if (stopBit !== 1'b1) begin
					errorCount++;
					$display("framing error, stop bit low after byte 0x%02h", rxByte);
				end
				if (expQ.size() == 0) begin
					errorCount++;
					$display("byte 0x%02h sent on txd with no frame requested", rxByte);
				end else begin
					expByte = expQ.pop_front();
					checkValue("txd byte", rxByte, expByte);
					bytesChecked++;
				end
			end
			prevTxd = txd;
		end
	end

	// length of each busy period.
	always @(negedge clk) begin
		if (busy === 1'b1) begin
			busyLen = busyLen + 1;
		end else if (busyLen != 0) begin
			if (busyLen < FrameCycles - BusyTolerance || busyLen > FrameCycles + BusyTolerance) begin
				checkValue("busy cycles", busyLen, FrameCycles);
			end
			framesSeen = framesSeen + 1;
			busyLen = 0;
		end
	end

	initial begin : watchdog
		#(WatchdogNs);
		$display("watchdog expired before the test rounds finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [frameReadoutPkg::NumChan-1:0] pattern;
		int holdCycles;
		int firstChan;
		seed = 32'hb5cfd916;
		rst = 1'b0;
		strobe = '0;
		wrEn = 1'b0;
		wrChan = '0;
		wrAdr = '0;
		wrData = '0;
		repeat (8) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		checkValue("txd", txd, 1'b1);
		checkValue("busy", busy, 1'b0);

		for (int c = 0; c < frameReadoutPkg::NumChan; c++) begin
			for (int w = 0; w < frameReadoutPkg::FrameWords; w++) begin
				writeWord(c, w, frameReadoutPkg::DataWidth'($random(seed)));
			end
		end
		repeat (300) @(negedge clk); // line must stay quiet.

		firstChan = $unsigned($random(seed)) % frameReadoutPkg::NumChan;
		for (int r = 0; r < NumRounds; r++) begin
			if (r == 0) begin
				pattern = frameReadoutPkg::NumChan'(1 << firstChan);
			end else if (r == 1) begin
				pattern = strobe | frameReadoutPkg::NumChan'($random(seed)); // first one held.
			end else begin
				pattern = frameReadoutPkg::NumChan'($random(seed));
			end
			if (r > 0) begin
				rewriteRandom($unsigned($random(seed)) % 8);
			end
			applyStrobes(pattern);
			holdCycles = 4 + $unsigned($random(seed)) % 64;
			repeat (holdCycles) @(negedge clk);
			waitIdle();
		end

		strobe = '0;
		repeat (20) @(negedge clk);
		checkValue("frame count", framesSeen, framesExpected);
		if (expQ.size() != 0) begin
			errorCount++;
			$display("%0d expected bytes never appeared on txd", expQ.size());
		end
		$display("errors %0d, bytes checked %0d, frames %0d", errorCount, bytesChecked,
			framesSeen);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
